//--- src/sdram_wr_defines.svh
`ifndef SDRAM_WR_DEFINES_SVH
`define SDRAM_WR_DEFINES_SVH

// number of user write channels, index 0 has the highest priority
`define WR_CH_NUM 3

// user and PHY data word width
`define WR_DATA_W 32

// words held by each channel FIFO, power of two
`define WR_FIFO_DEPTH 512

// columns per SDRAM row
`define WR_PAGE_WORDS 256

`endif

//--- src/sdram_addr_pkg.sv
`include "sdram_wr_defines.svh"

package sdram_addr_pkg;

    typedef logic [1:0]  sdram_bank_t;      // L-bank
    typedef logic [10:0] sdram_row_t;
    typedef logic [7:0]  sdram_col_t;

    // bank in the top bits, then row, then column
    typedef logic [20:0] sdram_addr_t;

    typedef logic [8:0]  burst_len_t;       // 1 to 256 words

    typedef logic [`WR_DATA_W-1:0] wr_data_t;

endpackage

//--- src/wr_ctrl_pkg.sv
`include "sdram_wr_defines.svh"

package wr_ctrl_pkg;

    // one bit per channel, one-hot or zero
    typedef logic [`WR_CH_NUM-1:0] grant_t;

    typedef enum logic [1:0] {
        ARB_IDLE,       // waiting for sdram init
        ARB_DECIDE,     // sampling requests
        ARB_GRANT       // one channel owns the sequencer
    } arb_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SETUP,      // latch address and count
        SEQ_LOAD,       // compute segment
        SEQ_REQ,
        SEQ_WAIT_ACK,
        SEQ_ACK_HIGH,
        SEQ_CHECK,      // second segment or finish
        SEQ_END
    } seq_state_t;

endpackage

//--- src/wr_arbiter.sv
`include "sdram_wr_defines.svh"

module wr_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sdram_init_done,
    input  logic [`WR_CH_NUM-1:0] ch_dr_en,
    input  logic                  trans_done,
    output wr_ctrl_pkg::grant_t   grant
);
    import wr_ctrl_pkg::*;

    arb_state_t            state;
    arb_state_t            state_nxt;
    logic [`WR_CH_NUM-1:0] request_q;
    grant_t                lowest;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (sdram_init_done)
                    state_nxt = ARB_DECIDE;
            end
            ARB_DECIDE: begin
                if (request_q != '0)
                    state_nxt = ARB_GRANT;
            end
            ARB_GRANT: begin
                if (trans_done)
                    state_nxt = ARB_DECIDE;
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    // refreshed on every cycle that ends in DECIDE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            request_q <= '0;
        end else if (state_nxt == ARB_DECIDE) begin
            request_q <= ch_dr_en;
        end
    end

    // isolate lowest set bit, lowest index wins
    assign lowest = request_q & (~request_q + 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else if (state_nxt == ARB_GRANT) begin
            grant <= lowest;            // request_q frozen while granted
        end else begin
            grant <= '0;
        end
    end

endmodule

//--- src/wr_channel_port.sv
`include "sdram_wr_defines.svh"

module wr_channel_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fi_en,
    input  sdram_addr_pkg::wr_data_t wr_data,
    input  logic                     granted,
    input  logic                     busy,
    input  logic                     pop,
    output sdram_addr_pkg::wr_data_t head_data,
    output logic                     ch_ack,
    output logic                     ch_done
);
    import sdram_addr_pkg::*;

    localparam int PTR_W = $clog2(`WR_FIFO_DEPTH);

    wr_data_t         mem [`WR_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             rd_en;
    logic             active;
    logic             active_q;

    assign rd_en = pop & granted;       // other channels' acks ignored

    always_ff @(posedge clk) begin
        if (fi_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fi_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // first word fall through
    assign head_data = mem[rd_ptr];

    assign active = granted & busy;

    // Edges of the served level become the user pulses, each one cycle
    // after the level changes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            ch_ack   <= 1'b0;
            ch_done  <= 1'b0;
        end else begin
            active_q <= active;
            ch_ack   <= active & ~active_q;
            ch_done  <= ~active & active_q;
        end
    end

endmodule

//--- src/burst_sequencer.sv
`include "sdram_wr_defines.svh"

module burst_sequencer (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  wr_ctrl_pkg::grant_t                          grant,
    input  sdram_addr_pkg::sdram_addr_t [`WR_CH_NUM-1:0] ch_addr,
    input  sdram_addr_pkg::burst_len_t  [`WR_CH_NUM-1:0] ch_number,
    input  sdram_addr_pkg::wr_data_t    [`WR_CH_NUM-1:0] fifo_data,
    input  logic                                         sdram_wr_ack,
    output logic                                         busy,
    output logic                                         pop,
    output logic                                         trans_done,
    output logic                                         sdram_wr_req,
    output sdram_addr_pkg::sdram_addr_t                  sdram_wr_addr,
    output sdram_addr_pkg::burst_len_t                   sdram_wr_byte,
    output sdram_addr_pkg::wr_data_t                     sdram_wr_data
);
    import sdram_addr_pkg::*;
    import wr_ctrl_pkg::*;

    localparam int PAGE_W = $bits(sdram_bank_t) + $bits(sdram_row_t);
    localparam int SUM_W  = $bits(burst_len_t) + 1;

    seq_state_t        state;
    seq_state_t        state_nxt;
    sdram_addr_t       sel_addr;
    burst_len_t        sel_number;
    wr_data_t          sel_data;
    sdram_addr_t       addr_lat;
    burst_len_t        number_lat;
    sdram_bank_t       lat_bank;
    sdram_row_t        lat_row;
    sdram_col_t        lat_col;
    logic [PAGE_W-1:0] next_page;
    logic [SUM_W-1:0]  end_col;
    logic              split;
    logic              second;
    sdram_addr_t       seg_addr;
    burst_len_t        seg_len;

    always_comb begin
        sel_addr   = '0;
        sel_number = '0;
        sel_data   = '0;
        for (int i = 0; i < `WR_CH_NUM; i++) begin
            if (grant[i]) begin
                sel_addr   = ch_addr[i];
                sel_number = ch_number[i];
                sel_data   = fifo_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_SETUP) begin
            addr_lat   <= sel_addr;
            number_lat <= sel_number;
        end
    end

    assign {lat_bank, lat_row, lat_col} = addr_lat;
    assign next_page = {lat_bank, lat_row} + 1'b1;      // bank carries on row wrap

    // one bit wider than the count so the sum never wraps
    assign end_col = SUM_W'(lat_col) + SUM_W'(number_lat);
    assign split   = end_col > SUM_W'(`WR_PAGE_WORDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: begin
                if (grant != '0)
                    state_nxt = SEQ_SETUP;
            end
            SEQ_SETUP:    state_nxt = SEQ_LOAD;
            SEQ_LOAD:     state_nxt = SEQ_REQ;
            SEQ_REQ:      state_nxt = SEQ_WAIT_ACK;
            SEQ_WAIT_ACK: begin
                if (sdram_wr_ack)
                    state_nxt = SEQ_ACK_HIGH;
            end
            SEQ_ACK_HIGH: begin
                if (!sdram_wr_ack)
                    state_nxt = SEQ_CHECK;
            end
            SEQ_CHECK: begin
                if (split && !second)
                    state_nxt = SEQ_LOAD;
                else
                    state_nxt = SEQ_END;
            end
            SEQ_END:      state_nxt = SEQ_IDLE;
            default:      state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second   <= 1'b0;
            seg_addr <= '0;
            seg_len  <= '0;
        end else begin
            if (state == SEQ_SETUP)
                second <= 1'b0;
            else if (state == SEQ_CHECK && split)
                second <= 1'b1;

            if (state == SEQ_LOAD) begin
                if (second) begin
                    seg_addr <= {next_page, sdram_col_t'(0)};   // column 0 of next row
                    seg_len  <= burst_len_t'(end_col - SUM_W'(`WR_PAGE_WORDS));
                end else if (split) begin
                    seg_addr <= addr_lat;
                    seg_len  <= burst_len_t'(SUM_W'(`WR_PAGE_WORDS) - SUM_W'(lat_col));
                end else begin
                    seg_addr <= addr_lat;
                    seg_len  <= number_lat;
                end
            end
        end
    end

    assign busy         = (state != SEQ_IDLE) && (state != SEQ_END);
    assign trans_done   = (state == SEQ_END);
    assign sdram_wr_req = (state == SEQ_REQ);
    assign pop          = sdram_wr_ack & busy;

    // held from the req pulse until the next LOAD
    assign sdram_wr_addr = seg_addr;
    assign sdram_wr_byte = seg_len;
    assign sdram_wr_data = sel_data;

endmodule

//--- src/sdram_wr_ctrl.sv
`include "sdram_wr_defines.svh"

module sdram_wr_ctrl (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         sdram_init_done,
    input  logic                                         sdram_wr_ack,
    output logic                                         sdram_wr_req,
    output sdram_addr_pkg::sdram_addr_t                  sdram_wr_addr,
    output sdram_addr_pkg::burst_len_t                   sdram_wr_byte,
    output sdram_addr_pkg::wr_data_t                     sdram_wr_data,
    input  logic                        [`WR_CH_NUM-1:0] ch_fi_en,
    input  sdram_addr_pkg::wr_data_t    [`WR_CH_NUM-1:0] ch_data,
    input  logic                        [`WR_CH_NUM-1:0] ch_dr_en,
    input  sdram_addr_pkg::sdram_addr_t [`WR_CH_NUM-1:0] ch_addr,
    input  sdram_addr_pkg::burst_len_t  [`WR_CH_NUM-1:0] ch_number,
    output logic                        [`WR_CH_NUM-1:0] ch_ack,
    output logic                        [`WR_CH_NUM-1:0] ch_done
);

    wr_ctrl_pkg::grant_t                          grant;
    logic                                         trans_done;
    logic                                         busy;
    logic                                         pop;
    sdram_addr_pkg::wr_data_t    [`WR_CH_NUM-1:0] fifo_data;

    wr_arbiter u_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .sdram_init_done (sdram_init_done),
        .ch_dr_en        (ch_dr_en),
        .trans_done      (trans_done),
        .grant           (grant)
    );

    for (genvar i = 0; i < `WR_CH_NUM; i++) begin : g_port
        wr_channel_port u_port (
            .clk       (clk),
            .rst_n     (rst_n),
            .fi_en     (ch_fi_en[i]),
            .wr_data   (ch_data[i]),
            .granted   (grant[i]),
            .busy      (busy),
            .pop       (pop),
            .head_data (fifo_data[i]),
            .ch_ack    (ch_ack[i]),
            .ch_done   (ch_done[i])
        );
    end

    burst_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .grant         (grant),
        .ch_addr       (ch_addr),
        .ch_number     (ch_number),
        .fifo_data     (fifo_data),
        .sdram_wr_ack  (sdram_wr_ack),
        .busy          (busy),
        .pop           (pop),
        .trans_done    (trans_done),
        .sdram_wr_req  (sdram_wr_req),
        .sdram_wr_addr (sdram_wr_addr),
        .sdram_wr_byte (sdram_wr_byte),
        .sdram_wr_data (sdram_wr_data)
    );

endmodule

//--- testbench/sdram_wr_ctrl_assertions.sv
`include "sdram_wr_defines.svh"

module sdram_wr_ctrl_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        sdram_wr_req,
    input sdram_addr_pkg::sdram_addr_t sdram_wr_addr,
    input sdram_addr_pkg::burst_len_t  sdram_wr_byte,
    input wr_ctrl_pkg::grant_t         grant
);
    import sdram_addr_pkg::*;

    int unsigned fail_cnt = 0;          // read by the testbench
    logic [9:0]  end_col;

    assign end_col = 10'(sdram_wr_addr[$bits(sdram_col_t)-1:0]) + 10'(sdram_wr_byte);

    req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_wr_req |=> !sdram_wr_req)
        else begin
            fail_cnt++;
            $error("sdram_wr_req high for more than one cycle");
        end

    grant_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else begin
            fail_cnt++;
            $error("grant has more than one bit set");
        end

    req_nonzero_len: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_wr_req |-> sdram_wr_byte != '0)
        else begin
            fail_cnt++;
            $error("sdram_wr_req with zero byte count");
        end

    // a burst never runs past the last column
    req_in_page: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_wr_req |-> end_col <= 10'(`WR_PAGE_WORDS))
        else begin
            fail_cnt++;
            $error("burst crosses the page boundary");
        end

endmodule

bind sdram_wr_ctrl sdram_wr_ctrl_assertions u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .sdram_wr_req  (sdram_wr_req),
    .sdram_wr_addr (sdram_wr_addr),
    .sdram_wr_byte (sdram_wr_byte),
    .grant         (grant)
);

//--- testbench/tb_sdram_wr_ctrl.sv
`include "sdram_wr_defines.svh"

module tb_sdram_wr_ctrl;
    import sdram_addr_pkg::*;

    localparam int TIMEOUT = 3000;

    typedef logic [`WR_CH_NUM-1:0] ch_mask_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        sdram_init_done;
    logic                        sdram_wr_ack = 1'b0;
    logic                        sdram_wr_req;
    sdram_addr_t                 sdram_wr_addr;
    burst_len_t                  sdram_wr_byte;
    wr_data_t                    sdram_wr_data;
    ch_mask_t                    ch_fi_en;
    wr_data_t [`WR_CH_NUM-1:0]   ch_data;
    ch_mask_t                    ch_dr_en;
    sdram_addr_t [`WR_CH_NUM-1:0] ch_addr;
    burst_len_t [`WR_CH_NUM-1:0] ch_number;
    ch_mask_t                    ch_ack;
    ch_mask_t                    ch_done;

    integer      seed = 13433;
    logic [29:0] seg_log[$];                // {addr, len} per PHY burst
    wr_data_t    word_log[$];
    wr_data_t    exp_words[`WR_CH_NUM][$];
    logic [31:0] exp_xfer[$];               // {ch, addr, count} in service order
    logic        in_xfer = 1'b0;

    sdram_wr_ctrl uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .sdram_init_done (sdram_init_done),
        .sdram_wr_ack    (sdram_wr_ack),
        .sdram_wr_req    (sdram_wr_req),
        .sdram_wr_addr   (sdram_wr_addr),
        .sdram_wr_byte   (sdram_wr_byte),
        .sdram_wr_data   (sdram_wr_data),
        .ch_fi_en        (ch_fi_en),
        .ch_data         (ch_data),
        .ch_dr_en        (ch_dr_en),
        .ch_addr         (ch_addr),
        .ch_number       (ch_number),
        .ch_ack          (ch_ack),
        .ch_done         (ch_done)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        stop_run();
    endtask

    // first segment runs to the page end, second starts at column 0 of the next page
    function automatic logic [1:0][29:0] expected_segments(input sdram_addr_t addr,
                                                            input burst_len_t count);
        logic [9:0]       first_len;
        logic [1:0][29:0] segs;
        first_len = 10'(`WR_PAGE_WORDS) - 10'(addr[7:0]);
        segs      = '0;
        if (10'(count) > first_len) begin
            segs[0] = {addr, first_len[8:0]};
            segs[1] = {addr[20:8] + 13'd1, 8'd0, 9'(10'(count) - first_len)};
        end else begin
            segs[0] = {addr, count};
        end
        return segs;
    endfunction

    // ack comes a few cycles after req, then stays high for the burst length
    always begin : phy_model
        burst_len_t len;
        @(negedge clk);
        if (rst_n && sdram_wr_req) begin
            len = sdram_wr_byte;
            seg_log.push_back({sdram_wr_addr, len});
            repeat (1 + len % 3) @(negedge clk);
            for (int k = 0; k < len; k++) begin
                sdram_wr_ack = 1'b1;
                word_log.push_back(sdram_wr_data);  // consumed at the next rising edge
                @(negedge clk);
            end
            sdram_wr_ack = 1'b0;
        end
    end

    always @(negedge clk) begin : compare_results
        logic [1:0][29:0] segs;
        logic [31:0]      xfer;
        int               nseg;
        wr_data_t         w;
        if (rst_n) begin
            assert (uut.u_sva.fail_cnt == 0) else report_failure("a bound protocol check fired");
            if (ch_ack != '0) begin
                assert ($onehot(ch_ack) && !in_xfer && exp_xfer.size() > 0)
                    else report_failure("ch_ack without exactly one pending transfer");
                assert (ch_ack[exp_xfer[0][31:30]])
                    else report_mismatch($sformatf("ch_ack %b, channel %0d expected",
                                                   ch_ack, exp_xfer[0][31:30]));
                assert (seg_log.size() == 0) else report_failure("sdram_wr_req came before ch_ack");
                in_xfer = 1'b1;
            end
            if (ch_done != '0) begin
                assert ($onehot(ch_done) && in_xfer) else report_failure("ch_done outside a transfer");
                xfer = exp_xfer.pop_front();
                assert (ch_done[xfer[31:30]])
                    else report_mismatch($sformatf("ch_done %b on wrong channel", ch_done));
                assert (!sdram_wr_ack) else report_failure("ch_done while PHY ack still high");
                segs = expected_segments(xfer[29:9], xfer[8:0]);
                nseg = (segs[1] != '0) ? 2 : 1;
                assert (seg_log.size() == nseg)
                    else report_mismatch($sformatf("%0d bursts, expected %0d", seg_log.size(), nseg));
                for (int s = 0; s < nseg; s++) begin
                    assert (seg_log[s] == segs[s])
                        else report_mismatch($sformatf("burst %0d addr/len %h, expected %h",
                                                       s, seg_log[s], segs[s]));
                end
                assert (word_log.size() == xfer[8:0])
                    else report_mismatch($sformatf("%0d words, expected %0d",
                                                   word_log.size(), xfer[8:0]));
                foreach (word_log[i]) begin
                    w = exp_words[xfer[31:30]].pop_front();
                    assert (word_log[i] == w)
                        else report_mismatch($sformatf("word %0d is %h, expected %h",
                                                       i, word_log[i], w));
                end
                seg_log.delete();
                word_log.delete();
                in_xfer = 1'b0;
            end
        end
    end

    // fill the FIFO with random words, then present address and count
    task automatic load_channel(input int ch, input sdram_addr_t addr, input burst_len_t count);
        wr_data_t w;
        for (int i = 0; i < count; i++) begin
            w            = $random(seed);
            ch_fi_en[ch] = 1'b1;
            ch_data[ch]  = w;
            exp_words[ch].push_back(w);
            @(negedge clk);
        end
        ch_fi_en[ch]  = 1'b0;
        ch_addr[ch]   = addr;
        ch_number[ch] = count;
        exp_xfer.push_back({2'(ch), addr, count});
    endtask

    task automatic serve_channels(input ch_mask_t mask);
        int dones;
        int cycles;
        dones    = 0;
        cycles   = 0;
        ch_dr_en = ch_dr_en | mask;
        while (dones < $countones(mask)) begin
            @(negedge clk);
            cycles++;
            ch_dr_en = ch_dr_en & ~ch_ack;      // request held until acked
            dones += $countones(ch_done & mask);
            assert (cycles <= TIMEOUT)
                else report_failure($sformatf("timeout, channels %b never all done", mask));
        end
        @(negedge clk);
    endtask

    initial begin
        int          ch;
        sdram_addr_t addr;
        burst_len_t  count;
        rst_n           = 1'b0;
        sdram_init_done = 1'b0;
        ch_fi_en        = '0;
        ch_data         = '0;
        ch_dr_en        = '0;
        ch_addr         = '0;
        ch_number       = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!sdram_wr_req && ch_ack == '0 && ch_done == '0 &&
                sdram_wr_addr == '0 && sdram_wr_byte == '0)
            else report_mismatch("outputs not low after reset");

        // request waits for sdram init
        load_channel(1, 21'h00_0010, 9'd8);
        ch_dr_en = ch_mask_t'(2);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            assert (ch_ack == '0 && !sdram_wr_req) else report_failure("served before sdram_init_done");
        end
        sdram_init_done = 1'b1;
        serve_channels(ch_mask_t'(2));

        load_channel(0, {2'd1, 11'd100, 8'd16}, 9'd32);
        serve_channels(ch_mask_t'(1));
        load_channel(2, {2'd0, 11'h7ff, 8'd200}, 9'd120);   // page and bank wrap
        serve_channels(ch_mask_t'(4));
        load_channel(1, {2'd3, 11'd5, 8'd255}, 9'd256);
        serve_channels(ch_mask_t'(2));

        for (int c = 0; c < `WR_CH_NUM; c++)
            load_channel(c, {2'(c), 11'(40 + c), 8'(100 * c)}, 9'(60 + 40 * c));
        serve_channels('1);

        for (int n = 0; n < 20; n++) begin
            ch    = {$random(seed)} % `WR_CH_NUM;
            addr  = sdram_addr_t'($random(seed));
            count = burst_len_t'(1 + {$random(seed)} % `WR_PAGE_WORDS);
            load_channel(ch, addr, count);
            serve_channels(ch_mask_t'(1 << ch));
        end

        @(negedge clk);
        if (uut.u_sva.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            report_failure("bound protocol checks failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/sdram_addr_pkg.sv
src/wr_ctrl_pkg.sv
src/wr_arbiter.sv
src/wr_channel_port.sv
src/burst_sequencer.sv
src/sdram_wr_ctrl.sv
testbench/sdram_wr_ctrl_assertions.sv
testbench/tb_sdram_wr_ctrl.sv

//--- Bender.yml
package:
  name: sdram_wr_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/sdram_addr_pkg.sv
      - src/wr_ctrl_pkg.sv
      - src/wr_arbiter.sv
      - src/wr_channel_port.sv
      - src/burst_sequencer.sv
      - src/sdram_wr_ctrl.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/sdram_wr_ctrl_assertions.sv
      - testbench/tb_sdram_wr_ctrl.sv
